// File: list.f
+incdir+include
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/hazard_forward.sv
verilog/datapath.sv
verilog/cpu_top.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

// File: tests/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

	localparam int NUM_TESTS  = 6;
	localparam int PROG_LEN   = 16;
	localparam int HALT_LIMIT = 2000;

	logic           clk;
	logic           reset_n;
	logic           read_m1, read_m2, write_m2, is_halted;
	logic           input_ready1, input_ready2, ack_output2;
	cpu_pkg::word_t address1, data1, address2, wdata2, rdata2;
	cpu_pkg::word_t num_inst, output_port;

	// toward the checker
	logic                        start, finish;
	int                          test_id, exp_len, exp_count, pass_count, fail_count;
	logic [4*`CPU_WORD_SIZE-1:0] exp_vals;

	// stimulus table, address 0 in the top word of each program
	logic [PROG_LEN*`CPU_WORD_SIZE-1:0] prog_tab [NUM_TESTS];
	cpu_pkg::word_t                     preset_addr [NUM_TESTS];
	cpu_pkg::word_t                     preset_val [NUM_TESTS];
	logic                               wait_tab [NUM_TESTS];
	logic [4*`CPU_WORD_SIZE-1:0]        wwd_tab [NUM_TESTS];
	int                                 wwd_len_tab [NUM_TESTS];
	int                                 count_tab [NUM_TESTS];

	// memory model state
	int             row, i_wait, d_wait;
	cpu_pkg::word_t dmem [256];
	logic [31:0]    lfsr;

	cpu_top u_cpu_top (.*);

	cpu_checker u_cpu_checker (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic cpu_pkg::word_t r_instr(input logic [5:0] func, input logic [1:0] rs,
		input logic [1:0] rt, input logic [1:0] rd);
		return {cpu_pkg::OP_RTYPE, rs, rt, rd, func};
	endfunction

	function automatic cpu_pkg::word_t i_instr(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpu_pkg::word_t j_instr(input logic [11:0] target);
		return {cpu_pkg::OP_JMP, target};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_delay(output int cycles);
		logic [1:0] bits;
		for (int k = 0; k < 2; k++) begin
			lfsr    = lfsr_step(lfsr);
			bits[k] = lfsr[0];
		end
		cycles = wait_tab[row] ? int'(bits) : 0;
	endtask

	task automatic fill_table();
		// forwarding chains and 16-bit wrap
		prog_tab[0] = {
			i_instr(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h7f),
			i_instr(cpu_pkg::OP_ADI, 2'd1, 2'd2, 8'hff),
			r_instr(cpu_pkg::FUNC_ADD, 2'd1, 2'd2, 2'd3),
			r_instr(cpu_pkg::FUNC_WWD, 2'd3, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_SUB, 2'd0, 2'd3, 2'd1),
			r_instr(cpu_pkg::FUNC_AND, 2'd1, 2'd3, 2'd2),
			r_instr(cpu_pkg::FUNC_WWD, 2'd2, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_ORR, 2'd2, 2'd1, 2'd3),
			r_instr(cpu_pkg::FUNC_ADD, 2'd3, 2'd3, 2'd3),
			r_instr(cpu_pkg::FUNC_WWD, 2'd3, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_HLT, 2'd0, 2'd0, 2'd0),
			{5{16'h0000}}
		};
		wwd_tab[0]     = {16'h0000, 16'hfe06, 16'h0001, 16'h00fd};
		wwd_len_tab[0] = 3;
		count_tab[0]   = 11;
		preset_addr[0] = 16'h0000;
		preset_val[0]  = 16'h0000;
		// store, load-use, preset word
		prog_tab[1] = {
			i_instr(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h25),
			i_instr(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h10),
			i_instr(cpu_pkg::OP_SWD, 2'd2, 2'd1, 8'h02),
			i_instr(cpu_pkg::OP_LWD, 2'd2, 2'd3, 8'h02),
			r_instr(cpu_pkg::FUNC_ADD, 2'd3, 2'd1, 2'd3),
			r_instr(cpu_pkg::FUNC_WWD, 2'd3, 2'd0, 2'd0),
			i_instr(cpu_pkg::OP_LWD, 2'd2, 2'd1, 8'h30),
			r_instr(cpu_pkg::FUNC_WWD, 2'd1, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_HLT, 2'd0, 2'd0, 2'd0),
			{7{16'h0000}}
		};
		wwd_tab[1]     = {16'h0000, 16'h0000, 16'hbeef, 16'h004a};
		wwd_len_tab[1] = 2;
		count_tab[1]   = 9;
		preset_addr[1] = 16'h0040;
		preset_val[1]  = 16'hbeef;
		// branches both ways and a jump, skipped slots would print
		prog_tab[2] = {
			i_instr(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h05),
			i_instr(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h05),
			i_instr(cpu_pkg::OP_BEQ, 2'd1, 2'd2, 8'h02),
			r_instr(cpu_pkg::FUNC_WWD, 2'd1, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_HLT, 2'd0, 2'd0, 2'd0),
			i_instr(cpu_pkg::OP_BNE, 2'd1, 2'd2, 8'h03),
			r_instr(cpu_pkg::FUNC_WWD, 2'd1, 2'd0, 2'd0),
			i_instr(cpu_pkg::OP_ADI, 2'd2, 2'd2, 8'h01),
			i_instr(cpu_pkg::OP_BNE, 2'd1, 2'd2, 8'h01),
			r_instr(cpu_pkg::FUNC_WWD, 2'd2, 2'd0, 2'd0),
			i_instr(cpu_pkg::OP_BEQ, 2'd1, 2'd2, 8'h02),
			j_instr(12'd13),
			r_instr(cpu_pkg::FUNC_HLT, 2'd0, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_WWD, 2'd2, 2'd0, 2'd0),
			r_instr(cpu_pkg::FUNC_HLT, 2'd0, 2'd0, 2'd0),
			16'h0000
		};
		wwd_tab[2]     = {16'h0000, 16'h0000, 16'h0006, 16'h0005};
		wwd_len_tab[2] = 2;
		count_tab[2]   = 11;
		preset_addr[2] = 16'h0000;
		preset_val[2]  = 16'h0000;
		// same three programs again with wait states
		for (int r = 0; r < 3; r++) begin
			prog_tab[r+3]    = prog_tab[r];
			wwd_tab[r+3]     = wwd_tab[r];
			wwd_len_tab[r+3] = wwd_len_tab[r];
			count_tab[r+3]   = count_tab[r];
			preset_addr[r+3] = preset_addr[r];
			preset_val[r+3]  = preset_val[r];
			wait_tab[r]      = 1'b0;
			wait_tab[r+3]    = 1'b1;
		end
	endtask

	task automatic apply_test(input int t);
		int  cyc;
		logic done;
		@(posedge clk);
		#1;
		reset_n   = 1'b0;
		test_id   = t;
		exp_vals  = wwd_tab[t];
		exp_len   = wwd_len_tab[t];
		exp_count = count_tab[t];
		start     = 1'b1;
		@(negedge clk);
		row = t;
		for (int a = 0; a < 256; a++) begin
			dmem[a] = cpu_pkg::word_t'(a * 257) ^ 16'h5a3c;
		end
		dmem[preset_addr[t][7:0]] = preset_val[t];
		for (int c = 0; c < 8; c++) begin
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		reset_n = 1'b1;
		done = 1'b0;
		cyc  = 0;
		while (!done && cyc < HALT_LIMIT) begin
			@(negedge clk);
			done = (is_halted === 1'b1);
			cyc++;
		end
		if (!done) begin
			$display("test %0d: processor did not halt", t);
		end
		@(posedge clk);
		#1;
		finish = 1'b1;
		@(posedge clk);
		#1;
		finish = 1'b0;
	endtask

	// both memories answer from one process, so the LFSR order is fixed
	initial begin
		forever begin
			@(posedge clk);
			#1;
			data1 = prog_tab[row][(PROG_LEN-1-address1[3:0])*`CPU_WORD_SIZE +: `CPU_WORD_SIZE];
			input_ready1 = (i_wait == 0);
			if (i_wait == 0) begin
				draw_delay(i_wait);
			end else begin
				i_wait--;
			end
			input_ready2 = 1'b0;
			ack_output2  = 1'b0;
			if (read_m2 === 1'b1 || write_m2 === 1'b1) begin
				if (d_wait == 0) begin
					input_ready2 = read_m2;
					ack_output2  = write_m2;
					rdata2       = dmem[address2[7:0]];
					if (write_m2) begin
						dmem[address2[7:0]] = wdata2;
					end
					draw_delay(d_wait);
				end else begin
					d_wait--;
				end
			end
		end
	end

	initial begin
		reset_n      = 1'b0;
		data1        = '0;
		input_ready1 = 1'b0;
		rdata2       = '0;
		input_ready2 = 1'b0;
		ack_output2  = 1'b0;
		start        = 1'b0;
		finish       = 1'b0;
		test_id      = 0;
		exp_vals     = '0;
		exp_len      = 0;
		exp_count    = 0;
		row          = 0;
		i_wait       = 0;
		d_wait       = 0;
		lfsr         = 32'h03a2_d204;
		fill_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			apply_test(t);
		end
		@(posedge clk);
		#1;
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: tests/cpu_checker.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_checker (
	input  logic                        clk,
	input  logic                        reset_n,
	input  cpu_pkg::word_t              output_port,
	input  cpu_pkg::word_t              num_inst,
	input  logic                        is_halted,
	input  logic                        read_m1,
	input  logic                        start,
	input  logic                        finish,
	input  int                          test_id,
	input  logic [4*`CPU_WORD_SIZE-1:0] exp_vals,
	input  int                          exp_len,
	input  int                          exp_count,
	output int                          pass_count,
	output int                          fail_count
);

	cpu_pkg::word_t prev_port;
	cpu_pkg::word_t want;
	int             seen;
	int             errors;

	initial begin
		pass_count = 0;
		fail_count = 0;
		seen       = 0;
		errors     = 0;
		prev_port  = '0;
	end

	// sampled half a cycle after the DUT outputs move
	always @(negedge clk) begin
		if (start) begin
			seen   = 0;
			errors = 0;
		end
		// fetch requests stay up until the core halts
		if (reset_n && is_halted !== 1'b1 && read_m1 !== 1'b1) begin
			$display("mismatch at %0t: test %0d read_m1 %b while running, expected 1",
				$time, test_id, read_m1);
			errors++;
		end
		if (!reset_n) begin
			prev_port = output_port;
		end else if (output_port !== prev_port) begin
			prev_port = output_port;
			if (seen >= exp_len) begin
				$display("mismatch at %0t: test %0d extra output_port value %h",
					$time, test_id, output_port);
				errors++;
			end else begin
				// first expected value sits in the low word
				want = exp_vals[seen*`CPU_WORD_SIZE +: `CPU_WORD_SIZE];
				if (output_port !== want) begin
					$display("mismatch at %0t: test %0d output_port %h, expected %h",
						$time, test_id, output_port, want);
					errors++;
				end
				seen++;
			end
		end
		if (finish) begin
			if (is_halted !== 1'b1) begin
				$display("test %0d: is_halted is low at the end of the test", test_id);
				errors++;
			end
			if (read_m1 !== 1'b0) begin
				$display("mismatch at %0t: test %0d read_m1 %b after halt, expected 0",
					$time, test_id, read_m1);
				errors++;
			end
			if (seen != exp_len) begin
				$display("test %0d: only %0d of %0d expected output values appeared",
					test_id, seen, exp_len);
				errors++;
			end
			if (num_inst !== cpu_pkg::word_t'(exp_count)) begin
				$display("mismatch at %0t: test %0d num_inst %0d, expected %0d",
					$time, test_id, num_inst, exp_count);
				errors++;
			end
			if (errors == 0) begin
				pass_count++;
				$display("test %0d: pass", test_id);
			end else begin
				fail_count++;
				$display("test %0d: fail with %0d errors", test_id, errors);
			end
		end
	end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic           clk,
	input  logic           reset_n,
	output logic           read_m1,
	output cpu_pkg::word_t address1,
	input  cpu_pkg::word_t data1,
	input  logic           input_ready1,
	output logic           read_m2,
	output logic           write_m2,
	output cpu_pkg::word_t address2,
	output cpu_pkg::word_t wdata2,
	input  cpu_pkg::word_t rdata2,
	input  logic           input_ready2,
	input  logic           ack_output2,
	output cpu_pkg::word_t num_inst,
	output cpu_pkg::word_t output_port,
	output logic           is_halted
);

	// register file side of the datapath
	cpu_pkg::reg_idx_t rs_idx, rt_idx, wr_idx;
	cpu_pkg::word_t    rs_data, rt_data, wr_data;
	logic              wr_en;

	datapath u_datapath (.*);

	register_file u_register_file (.*);

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapath (
	input  logic              clk,
	input  logic              reset_n,
	output logic              read_m1,
	output cpu_pkg::word_t    address1,
	input  cpu_pkg::word_t    data1,
	input  logic              input_ready1,
	output logic              read_m2,
	output logic              write_m2,
	output cpu_pkg::word_t    address2,
	output cpu_pkg::word_t    wdata2,
	input  cpu_pkg::word_t    rdata2,
	input  logic              input_ready2,
	input  logic              ack_output2,
	output cpu_pkg::word_t    num_inst,
	output cpu_pkg::word_t    output_port,
	output logic              is_halted,
	output cpu_pkg::reg_idx_t rs_idx,
	output cpu_pkg::reg_idx_t rt_idx,
	input  cpu_pkg::word_t    rs_data,
	input  cpu_pkg::word_t    rt_data,
	output logic              wr_en,
	output cpu_pkg::reg_idx_t wr_idx,
	output cpu_pkg::word_t    wr_data
);

	// IF and ID
	cpu_pkg::word_t    pc, id_pc, id_instr;
	logic              id_valid, id_hold, load_stall, halt_ahead;
	logic              dec_reg_write, dec_use_rs, dec_use_rt, dec_alu_src_imm;
	logic              dec_jump, dec_mem_read, dec_mem_write, dec_wwd, dec_halt;
	cpu_pkg::alu_op_t  dec_alu_op;
	cpu_pkg::branch_t  dec_branch;
	cpu_pkg::wb_sel_t  dec_wb_sel;
	cpu_pkg::reg_idx_t dec_dest;

	// EX
	cpu_pkg::word_t    ex_pc, ex_instr, ex_rs_val, ex_rt_val;
	logic              ex_valid, ex_reg_write, ex_alu_src_imm, ex_jump;
	logic              ex_mem_read, ex_mem_write, ex_wwd, ex_halt;
	cpu_pkg::alu_op_t  ex_alu_op;
	cpu_pkg::branch_t  ex_branch;
	cpu_pkg::wb_sel_t  ex_wb_sel;
	cpu_pkg::reg_idx_t ex_dest;
	cpu_pkg::fwd_sel_t fwd_a, fwd_b;
	cpu_pkg::word_t    opnd_a, opnd_b, alu_b, alu_result, ex_imm, ex_target;
	logic              br_taken, redirect;

	// MEM
	cpu_pkg::word_t    mm_alu, mm_store;
	logic              mm_valid, mm_reg_write, mm_mem_read, mm_mem_write, mm_wwd, mm_halt;
	logic              mem_wait;
	cpu_pkg::wb_sel_t  mm_wb_sel;
	cpu_pkg::reg_idx_t mm_dest;

	// WB
	cpu_pkg::word_t    wb_alu, wb_mem_data, wb_store, wb_data;
	logic              wb_valid, wb_reg_write, wb_wwd, wb_halt, wb_commit, halted;
	cpu_pkg::wb_sel_t  wb_wb_sel;
	cpu_pkg::reg_idx_t wb_dest;

	control_unit u_control_unit (
		.instr(id_instr), .reg_write(dec_reg_write),
		.use_rs(dec_use_rs), .use_rt(dec_use_rt),
		.alu_src_imm(dec_alu_src_imm), .alu_op(dec_alu_op),
		.branch(dec_branch), .jump(dec_jump),
		.mem_read(dec_mem_read), .mem_write(dec_mem_write),
		.wb_sel(dec_wb_sel), .dest(dec_dest),
		.wwd(dec_wwd), .halt(dec_halt)
	);

	hazard_forward u_hazard_forward (
		.id_rs(id_instr[11:10]), .id_rt(id_instr[9:8]),
		.id_use_rs(id_valid & dec_use_rs), .id_use_rt(id_valid & dec_use_rt),
		.ex_dest(ex_dest), .ex_mem_read(ex_valid & ex_mem_read),
		.ex_rs(ex_instr[11:10]), .ex_rt(ex_instr[9:8]),
		.mem_dest(mm_dest), .mem_reg_write(mm_valid & mm_reg_write),
		.wb_dest(wb_dest), .wb_reg_write(wb_valid & wb_reg_write),
		.stall(load_stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	alu u_alu (
		.a(opnd_a), .b(alu_b), .op(ex_alu_op), .branch(ex_branch),
		.result(alu_result), .taken(br_taken)
	);

	assign read_m1  = ~halted;
	assign address1 = pc;
	assign rs_idx   = id_instr[11:10];
	assign rt_idx   = id_instr[9:8];

	// an unanswered data access freezes every stage
	assign mem_wait = mm_valid & ((mm_mem_read & ~input_ready2) | (mm_mem_write & ~ack_output2));
	assign id_hold  = load_stall | ~input_ready1;
	// nothing younger than HLT may leave ID
	assign halt_ahead = (ex_valid & ex_halt) | (mm_valid & mm_halt) | (wb_valid & wb_halt) | halted;

	always_comb begin
		case (fwd_a)
			cpu_pkg::FWD_MEM: opnd_a = mm_alu;
			cpu_pkg::FWD_WB:  opnd_a = wb_data;
			default:          opnd_a = ex_rs_val;
		endcase
		case (fwd_b)
			cpu_pkg::FWD_MEM: opnd_b = mm_alu;
			cpu_pkg::FWD_WB:  opnd_b = wb_data;
			default:          opnd_b = ex_rt_val;
		endcase
	end

	assign ex_imm = {{(`CPU_WORD_SIZE-`CPU_IMM_BITS){ex_instr[`CPU_IMM_BITS-1]}},
		ex_instr[`CPU_IMM_BITS-1:0]};
	assign alu_b  = ex_alu_src_imm ? ex_imm : opnd_b;
	// JMP keeps the top PC bits, branches are PC relative
	assign ex_target = ex_jump ? {ex_pc[`CPU_WORD_SIZE-1:12], ex_instr[11:0]}
		: ex_pc + cpu_pkg::word_t'(1) + ex_imm;
	assign redirect = ex_valid & (ex_jump | br_taken);

	assign read_m2  = mm_valid & mm_mem_read;
	assign write_m2 = mm_valid & mm_mem_write;
	assign address2 = mm_alu;
	assign wdata2   = mm_store;

	assign wb_data   = (wb_wb_sel == cpu_pkg::WB_MEM) ? wb_mem_data : wb_alu;
	assign wb_commit = wb_valid & ~mem_wait;
	assign wr_en     = wb_commit & wb_reg_write;
	assign wr_idx    = wb_dest;
	assign wr_data   = wb_data;
	assign is_halted = halted;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc          <= cpu_pkg::word_t'(`CPU_RESET_PC);
			id_valid    <= 1'b0;
			ex_valid    <= 1'b0;
			mm_valid    <= 1'b0;
			wb_valid    <= 1'b0;
			num_inst    <= '0;
			output_port <= '0;
			halted      <= 1'b0;
		end else begin
			if (!mem_wait) begin
				if (redirect) begin
					pc <= ex_target;
				end else if (!id_hold && !halt_ahead) begin
					pc <= pc + cpu_pkg::word_t'(1);
				end
				// mispredict kills the two younger slots
				if (redirect || halt_ahead) begin
					id_valid <= 1'b0;
				end else if (!id_hold) begin
					id_valid <= 1'b1;
				end
				ex_valid <= id_valid & ~redirect & ~id_hold & ~halt_ahead;
				mm_valid <= ex_valid;
				wb_valid <= mm_valid;
			end
			if (wb_commit) begin
				num_inst <= num_inst + cpu_pkg::word_t'(1);
				if (wb_wwd) begin
					output_port <= wb_store;
				end
				if (wb_halt) begin
					halted <= 1'b1;
				end
			end
		end
	end

	// payload and control fields, qualified by the valid bits
	always_ff @(posedge clk) begin
		if (!mem_wait) begin
			if (!id_hold) begin
				id_pc    <= pc;
				id_instr <= data1;
			end
			ex_pc          <= id_pc;
			ex_instr       <= id_instr;
			ex_rs_val      <= rs_data;
			ex_rt_val      <= rt_data;
			ex_reg_write   <= dec_reg_write;
			ex_alu_src_imm <= dec_alu_src_imm;
			ex_alu_op      <= dec_alu_op;
			ex_branch      <= dec_branch;
			ex_jump        <= dec_jump;
			ex_mem_read    <= dec_mem_read;
			ex_mem_write   <= dec_mem_write;
			ex_wb_sel      <= dec_wb_sel;
			ex_dest        <= dec_dest;
			ex_wwd         <= dec_wwd;
			ex_halt        <= dec_halt;

			mm_alu       <= alu_result;
			// store data for SWD, the output value for WWD
			mm_store     <= ex_wwd ? opnd_a : opnd_b;
			mm_reg_write <= ex_reg_write;
			mm_mem_read  <= ex_mem_read;
			mm_mem_write <= ex_mem_write;
			mm_wb_sel    <= ex_wb_sel;
			mm_dest      <= ex_dest;
			mm_wwd       <= ex_wwd;
			mm_halt      <= ex_halt;

			wb_alu       <= mm_alu;
			wb_mem_data  <= rdata2;
			wb_store     <= mm_store;
			wb_reg_write <= mm_reg_write;
			wb_wb_sel    <= mm_wb_sel;
			wb_dest      <= mm_dest;
			wb_wwd       <= mm_wwd;
			wb_halt      <= mm_halt;
		end
	end

	a_rw_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(read_m2 && write_m2));

	// memory sees one steady request until it answers
	a_addr2_stable: assert property (@(posedge clk) disable iff (!reset_n)
		mem_wait |=> $stable(address2));

endmodule

// File: verilog/hazard_forward.sv
`timescale 1ns/1ps

module hazard_forward (
	input  cpu_pkg::reg_idx_t id_rs,
	input  cpu_pkg::reg_idx_t id_rt,
	input  logic              id_use_rs,
	input  logic              id_use_rt,
	input  cpu_pkg::reg_idx_t ex_dest,
	input  logic              ex_mem_read,
	input  cpu_pkg::reg_idx_t ex_rs,
	input  cpu_pkg::reg_idx_t ex_rt,
	input  cpu_pkg::reg_idx_t mem_dest,
	input  logic              mem_reg_write,
	input  cpu_pkg::reg_idx_t wb_dest,
	input  logic              wb_reg_write,
	output logic              stall,
	output cpu_pkg::fwd_sel_t fwd_a,
	output cpu_pkg::fwd_sel_t fwd_b
);

	// load data only exists once the load reaches WB
	assign stall = ex_mem_read &&
		((id_use_rs && id_rs == ex_dest) || (id_use_rt && id_rt == ex_dest));

	// the younger producer in MEM shadows an older one in WB
	function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_idx_t src);
		if (mem_reg_write && mem_dest == src) begin
			return cpu_pkg::FWD_MEM;
		end
		if (wb_reg_write && wb_dest == src) begin
			return cpu_pkg::FWD_WB;
		end
		return cpu_pkg::FWD_REG;
	endfunction

	always_comb begin
		fwd_a = pick(ex_rs);
		fwd_b = pick(ex_rt);
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::branch_t branch,
	output cpu_pkg::word_t   result,
	output logic             taken
);

	// sums and differences wrap at the word width
	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD:    result = a + b;
			cpu_pkg::ALU_SUB:    result = a - b;
			cpu_pkg::ALU_AND:    result = a & b;
			cpu_pkg::ALU_OR:     result = a | b;
			cpu_pkg::ALU_PASS_B: result = b;
			default:             result = '0;
		endcase
	end

	// branch condition on the two forwarded register values
	always_comb begin
		case (branch)
			cpu_pkg::BR_NE: taken = (a != b);
			cpu_pkg::BR_EQ: taken = (a == b);
			default:        taken = 1'b0;
		endcase
	end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
	input  logic              clk,
	input  logic              reset_n,
	input  cpu_pkg::reg_idx_t rs_idx,
	input  cpu_pkg::reg_idx_t rt_idx,
	output cpu_pkg::word_t    rs_data,
	output cpu_pkg::word_t    rt_data,
	input  logic              wr_en,
	input  cpu_pkg::reg_idx_t wr_idx,
	input  cpu_pkg::word_t    wr_data
);

	cpu_pkg::word_t regs [`CPU_NUM_REGS];

	// a write in WB is visible to the ID read in the same cycle
	assign rs_data = (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
	assign rt_data = (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	a_wr_idx_known: assert property (@(posedge clk) disable iff (!reset_n)
		wr_en |-> !$isunknown(wr_idx));

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  cpu_pkg::word_t    instr,
	output logic              reg_write,
	output logic              use_rs,
	output logic              use_rt,
	output logic              alu_src_imm,
	output cpu_pkg::alu_op_t  alu_op,
	output cpu_pkg::branch_t  branch,
	output logic              jump,
	output logic              mem_read,
	output logic              mem_write,
	output cpu_pkg::wb_sel_t  wb_sel,
	output cpu_pkg::reg_idx_t dest,
	output logic              wwd,
	output logic              halt
);

	always_comb begin
		// everything off is a no-op
		reg_write   = 1'b0;
		use_rs      = 1'b0;
		use_rt      = 1'b0;
		alu_src_imm = 1'b0;
		alu_op      = cpu_pkg::ALU_PASS_B;
		branch      = cpu_pkg::BR_NONE;
		jump        = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		wb_sel      = cpu_pkg::WB_ALU;
		dest        = instr[7:6];
		wwd         = 1'b0;
		halt        = 1'b0;

		case (instr[15:12])
			cpu_pkg::OP_RTYPE: begin
				case (instr[5:0])
					cpu_pkg::FUNC_ADD: alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FUNC_SUB: alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FUNC_AND: alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FUNC_ORR: alu_op = cpu_pkg::ALU_OR;
					default: ;
				endcase
				case (instr[5:0])
					cpu_pkg::FUNC_ADD, cpu_pkg::FUNC_SUB,
					cpu_pkg::FUNC_AND, cpu_pkg::FUNC_ORR: begin
						reg_write = 1'b1;
						use_rs    = 1'b1;
						use_rt    = 1'b1;
					end
					cpu_pkg::FUNC_WWD: begin
						use_rs = 1'b1;
						wwd    = 1'b1;
					end
					cpu_pkg::FUNC_HLT: halt = 1'b1;
					default: ;
				endcase
			end
			cpu_pkg::OP_BNE, cpu_pkg::OP_BEQ: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				branch = (instr[15:12] == cpu_pkg::OP_BNE) ? cpu_pkg::BR_NE : cpu_pkg::BR_EQ;
			end
			cpu_pkg::OP_ADI, cpu_pkg::OP_LWD, cpu_pkg::OP_SWD: begin
				// base plus offset, or register plus immediate
				use_rs      = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = cpu_pkg::ALU_ADD;
				dest        = instr[9:8];
				reg_write   = (instr[15:12] != cpu_pkg::OP_SWD);
				use_rt      = (instr[15:12] == cpu_pkg::OP_SWD);
				mem_write   = (instr[15:12] == cpu_pkg::OP_SWD);
				mem_read    = (instr[15:12] == cpu_pkg::OP_LWD);
				wb_sel      = (instr[15:12] == cpu_pkg::OP_LWD) ? cpu_pkg::WB_MEM : cpu_pkg::WB_ALU;
			end
			cpu_pkg::OP_JMP: jump = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: verilog/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_SIZE-1:0] word_t;
	typedef logic [1:0] reg_idx_t;
	typedef logic [2:0] alu_op_t;
	typedef logic [1:0] branch_t;
	typedef logic       wb_sel_t;
	typedef logic [1:0] fwd_sel_t;

	// major opcodes, instruction bits 15..12
	localparam logic [3:0] OP_BNE   = 4'd0;
	localparam logic [3:0] OP_BEQ   = 4'd1;
	localparam logic [3:0] OP_ADI   = 4'd4;
	localparam logic [3:0] OP_LWD   = 4'd7;
	localparam logic [3:0] OP_SWD   = 4'd8;
	localparam logic [3:0] OP_JMP   = 4'd9;
	localparam logic [3:0] OP_RTYPE = 4'd15;

	// R-type func codes, bits 5..0
	localparam logic [5:0] FUNC_ADD = 6'd0;
	localparam logic [5:0] FUNC_SUB = 6'd1;
	localparam logic [5:0] FUNC_AND = 6'd2;
	localparam logic [5:0] FUNC_ORR = 6'd3;
	localparam logic [5:0] FUNC_WWD = 6'd28;
	localparam logic [5:0] FUNC_HLT = 6'd29;

	localparam alu_op_t ALU_ADD    = 3'd0;
	localparam alu_op_t ALU_SUB    = 3'd1;
	localparam alu_op_t ALU_AND    = 3'd2;
	localparam alu_op_t ALU_OR     = 3'd3;
	localparam alu_op_t ALU_PASS_B = 3'd4;

	localparam branch_t BR_NONE = 2'd0;
	localparam branch_t BR_NE   = 2'd1;
	localparam branch_t BR_EQ   = 2'd2;

	localparam wb_sel_t WB_ALU = 1'b0;
	localparam wb_sel_t WB_MEM = 1'b1;

	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_MEM = 2'd1;
	localparam fwd_sel_t FWD_WB  = 2'd2;

endpackage

// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width
`define CPU_WORD_SIZE 16

// general registers visible to software
// the register index type in the package is sized for this count
`define CPU_NUM_REGS 4

// first fetch address after reset
`define CPU_RESET_PC 0

// immediate field of I-type words, sign-extended to a full word
`define CPU_IMM_BITS 8

`endif
